// File: hdl/ex_pkg.sv
package ex_pkg;

    localparam int xlen      = 64; // data word
    localparam int reg_idx_w = 5;  // x0..x31

    // major opcodes handled here
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // alu ops, OP and OP-IMM share them
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101; // also sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // M extension subset
    localparam logic [2:0] f3_mul  = 3'b000;
    localparam logic [2:0] f3_div  = 3'b100;
    localparam logic [2:0] f3_divu = 3'b101;
    localparam logic [2:0] f3_remu = 3'b111;

    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000; // sub, sra
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    // writeback source
    localparam logic [1:0] sel_none   = 2'd0;
    localparam logic [1:0] sel_alu    = 2'd1;
    localparam logic [1:0] sel_link   = 2'd2;
    localparam logic [1:0] sel_muldiv = 2'd3;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic       imm12;   // offset sign
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
    } inst_u;

endpackage

// File: hdl/muldiv_if.sv
interface muldiv_if;

    logic                    start;  // one-cycle request pulse
    logic [2:0]              funct3; // mul, div, divu, remu
    logic                    done;   // one-cycle completion pulse
    logic [ex_pkg::xlen-1:0] result; // held after done

    modport ctrl (output start, output funct3, input done);

    modport unit (input start, input funct3, output done, output result);

    modport sink (input result);

endinterface

// File: hdl/ex_control.sv
module ex_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  logic [ex_pkg::xlen-1:0] in_pc,
    input  logic [31:0]             in_inst,
    input  logic [ex_pkg::xlen-1:0] in_rs1_val,
    input  logic [ex_pkg::xlen-1:0] in_rs2_val,
    input  logic                    branch_flush,
    input  logic                    out_ready,
    output logic                    in_ready,
    output logic                    out_valid,
    output logic [ex_pkg::xlen-1:0] out_pc,
    output logic                    out_wen,
    output logic [1:0]              res_sel,
    output logic                    is_jalr,
    output logic                    is_branch_xfer,
    output ex_pkg::inst_u           ex_inst,
    output logic [ex_pkg::xlen-1:0] rs1_val,
    output logic [ex_pkg::xlen-1:0] rs2_val,
    muldiv_if.ctrl                  md
);

    logic valid_q;
    logic md_issued; // start already sent for the occupant
    logic md_fin;    // done seen, result ready
    logic md_drain;  // a flushed op is still running in the unit
    logic is_alu;
    logic is_md;
    logic is_br;

    // instruction class
    always_comb begin
        is_alu  = 1'b0;
        is_md   = 1'b0;
        is_br   = 1'b0;
        is_jalr = 1'b0;
        case (ex_inst.r_view.opcode)
            ex_pkg::op_reg: begin
                if (ex_inst.r_view.funct7 == ex_pkg::f7_base)
                    is_alu = 1'b1;
                else if (ex_inst.r_view.funct7 == ex_pkg::f7_alt) // sub, sra only
                    is_alu = ex_inst.r_view.funct3 inside {ex_pkg::f3_add, ex_pkg::f3_srl};
                else if (ex_inst.r_view.funct7 == ex_pkg::f7_muldiv)
                    is_md = ex_inst.r_view.funct3 inside
                        {ex_pkg::f3_mul, ex_pkg::f3_div, ex_pkg::f3_divu, ex_pkg::f3_remu};
            end
            ex_pkg::op_imm: begin
                // shifts need a clean upper immediate, srai has bit 10 set
                if (ex_inst.i_view.funct3 == ex_pkg::f3_sll)
                    is_alu = ex_inst.i_view.imm12[11:6] == 6'b000000;
                else if (ex_inst.i_view.funct3 == ex_pkg::f3_srl)
                    is_alu = ex_inst.i_view.imm12[11:6] inside {6'b000000, 6'b010000};
                else
                    is_alu = 1'b1;
            end
            ex_pkg::op_branch: is_br = ex_inst.b_view.funct3 inside {ex_pkg::f3_beq,
                ex_pkg::f3_bne, ex_pkg::f3_blt, ex_pkg::f3_bge, ex_pkg::f3_bltu, ex_pkg::f3_bgeu};
            ex_pkg::op_jalr:   is_jalr = ex_inst.i_view.funct3 == 3'b000;
            default: ;
        endcase
    end

    assign res_sel = is_alu  ? ex_pkg::sel_alu :
                     is_jalr ? ex_pkg::sel_link :
                     is_md   ? ex_pkg::sel_muldiv : ex_pkg::sel_none;
    assign out_wen = (is_alu || is_jalr || is_md) && ex_inst.r_view.rd != '0; // x0 never written

    // muldiv holds the slot until its result is back
    assign out_valid      = valid_q && (!is_md || md_fin);
    assign in_ready       = (!valid_q || (out_valid && out_ready)) && !branch_flush;
    assign is_branch_xfer = out_valid && out_ready && (is_br || is_jalr);

    assign md.start  = valid_q && is_md && !md_issued && !md_drain && !branch_flush;
    assign md.funct3 = ex_inst.r_view.funct3;

    always_ff @(posedge clk) begin
        if (reset || branch_flush)
            valid_q <= 1'b0;
        else if (in_ready)
            valid_q <= in_valid; // refill or empty
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pc  <= in_pc;
            ex_inst <= in_inst;
            rs1_val <= in_rs1_val;
            rs2_val <= in_rs2_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || in_ready) begin // new occupant or empty slot
            md_issued <= 1'b0;
            md_fin    <= 1'b0;
        end else begin
            if (md.start)
                md_issued <= 1'b1;
            if (md.done && md_issued)
                md_fin <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || md.done)
            md_drain <= 1'b0;
        else if (branch_flush && md_issued && !md_fin)
            md_drain <= 1'b1; // unit busy with a dropped op
    end

    a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid);
    // each done answers the occupant's request or a dropped one
    a_done_owned: assert property (@(posedge clk) disable iff (reset)
        md.done |-> (md_issued && !md_fin) || md_drain);

endmodule

// File: hdl/ex_forward.sv
module ex_forward (
    input  ex_pkg::inst_u                ex_inst,
    input  logic [ex_pkg::xlen-1:0]      rs1_val,
    input  logic [ex_pkg::xlen-1:0]      rs2_val,
    input  logic                         mem_fwd_valid,
    input  logic [ex_pkg::reg_idx_w-1:0] mem_fwd_rd,
    input  logic [ex_pkg::xlen-1:0]      mem_fwd_data,
    input  logic                         wb_fwd_valid,
    input  logic [ex_pkg::reg_idx_w-1:0] wb_fwd_rd,
    input  logic [ex_pkg::xlen-1:0]      wb_fwd_data,
    output logic [ex_pkg::xlen-1:0]      src1,
    output logic [ex_pkg::xlen-1:0]      src2
);

    // newest producer wins, x0 is never bypassed
    function automatic logic [ex_pkg::xlen-1:0] pick(
        input logic [ex_pkg::reg_idx_w-1:0] rs,
        input logic [ex_pkg::xlen-1:0]      reg_val
    );
        if (rs == '0)
            return reg_val;
        if (mem_fwd_valid && mem_fwd_rd == rs)
            return mem_fwd_data;
        if (wb_fwd_valid && wb_fwd_rd == rs)
            return wb_fwd_data;
        return reg_val;
    endfunction

    always_comb begin
        src1 = pick(ex_inst.r_view.rs1, rs1_val);
        src2 = pick(ex_inst.r_view.rs2, rs2_val);
    end

endmodule

// File: hdl/ex_alu.sv
module ex_alu (
    input  ex_pkg::inst_u           ex_inst,
    input  logic [ex_pkg::xlen-1:0] out_pc,
    input  logic [ex_pkg::xlen-1:0] src1,
    input  logic [ex_pkg::xlen-1:0] src2,
    input  logic [1:0]              res_sel,
    output logic [ex_pkg::xlen-1:0] out_result,
    muldiv_if.sink                  md
);

    logic [ex_pkg::xlen-1:0] imm_i;
    logic [ex_pkg::xlen-1:0] op_b;
    logic [ex_pkg::xlen-1:0] alu_res;
    logic [5:0]              shamt;
    logic                    alt; // sub / sra

    assign imm_i = {{(ex_pkg::xlen-12){ex_inst.i_view.imm12[11]}}, ex_inst.i_view.imm12};
    assign op_b  = (ex_inst.i_view.opcode == ex_pkg::op_imm) ? imm_i : src2;
    assign shamt = op_b[5:0]; // imm[5:0] for the immediate shifts
    // OP-IMM has no subi, so bit 30 only counts for srai there
    assign alt   = ex_inst.r_view.funct7[5] &&
                   (ex_inst.r_view.opcode == ex_pkg::op_reg ||
                    ex_inst.r_view.funct3 == ex_pkg::f3_srl);

    always_comb begin
        case (ex_inst.r_view.funct3)
            ex_pkg::f3_add:  alu_res = alt ? src1 - op_b : src1 + op_b;
            ex_pkg::f3_sll:  alu_res = src1 << shamt;
            ex_pkg::f3_slt:  alu_res = {63'd0, $signed(src1) < $signed(op_b)};
            ex_pkg::f3_sltu: alu_res = {63'd0, src1 < op_b};
            ex_pkg::f3_xor:  alu_res = src1 ^ op_b;
            ex_pkg::f3_srl:  alu_res = alt ? $unsigned($signed(src1) >>> shamt) : src1 >> shamt;
            ex_pkg::f3_or:   alu_res = src1 | op_b;
            default:         alu_res = src1 & op_b;
        endcase
    end

    // writeback mux
    always_comb begin
        case (res_sel)
            ex_pkg::sel_alu:    out_result = alu_res;
            ex_pkg::sel_link:   out_result = out_pc + 4; // jalr return address
            ex_pkg::sel_muldiv: out_result = md.result;
            default:            out_result = '0;
        endcase
    end

endmodule

// File: hdl/ex_branch.sv
module ex_branch (
    input  ex_pkg::inst_u           ex_inst,
    input  logic [ex_pkg::xlen-1:0] out_pc,
    input  logic [ex_pkg::xlen-1:0] src1,
    input  logic [ex_pkg::xlen-1:0] src2,
    input  logic                    is_jalr,
    output logic                    mispredict,
    output logic [ex_pkg::xlen-1:0] fix_pc
);

    logic [ex_pkg::xlen-1:0] off_b;
    logic [ex_pkg::xlen-1:0] imm_i;
    logic [ex_pkg::xlen-1:0] jump_sum;
    logic                    taken;

    // B offset, scattered fields put back in order
    assign off_b = {{(ex_pkg::xlen-13){ex_inst.b_view.imm12}}, ex_inst.b_view.imm12,
                    ex_inst.b_view.imm11, ex_inst.b_view.imm10_5, ex_inst.b_view.imm4_1, 1'b0};
    assign imm_i = {{(ex_pkg::xlen-12){ex_inst.i_view.imm12[11]}}, ex_inst.i_view.imm12};
    assign jump_sum = src1 + imm_i;

    always_comb begin
        case (ex_inst.b_view.funct3)
            ex_pkg::f3_beq:  taken = src1 == src2;
            ex_pkg::f3_bne:  taken = src1 != src2;
            ex_pkg::f3_blt:  taken = $signed(src1) < $signed(src2);
            ex_pkg::f3_bge:  taken = $signed(src1) >= $signed(src2);
            ex_pkg::f3_bltu: taken = src1 < src2;
            ex_pkg::f3_bgeu: taken = src1 >= src2;
            default:         taken = 1'b0;
        endcase
    end

    // backward branch predicted taken, jalr target never known up front
    assign mispredict = is_jalr || (taken != ex_inst.b_view.imm12);
    assign fix_pc     = is_jalr ? {jump_sum[ex_pkg::xlen-1:1], 1'b0} :
                        taken   ? out_pc + off_b : out_pc + 4;

endmodule

// File: hdl/ex_muldiv.sv
module ex_muldiv (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [ex_pkg::xlen-1:0] op_a,
    input  logic [ex_pkg::xlen-1:0] op_b,
    muldiv_if.unit                  md
);

    logic                    busy;
    logic [6:0]              cnt;   // 0..63 steps, 64 is the finish cycle
    logic                    last;
    logic [2:0]              f3_q;
    logic                    neg_q; // negate the div quotient at the end
    logic [ex_pkg::xlen-1:0] hi;    // product acc / partial remainder
    logic [ex_pkg::xlen-1:0] lo;    // multiplier / dividend turning into quotient
    logic [ex_pkg::xlen-1:0] b_q;   // multiplicand / divisor
    logic [ex_pkg::xlen:0]   rem_sh;
    logic [ex_pkg::xlen:0]   diff;
    logic                    is_signed;
    logic [ex_pkg::xlen-1:0] a_mag;
    logic [ex_pkg::xlen-1:0] b_mag;

    assign is_signed = md.funct3 == ex_pkg::f3_div;
    assign a_mag = (is_signed && op_a[ex_pkg::xlen-1]) ? -op_a : op_a;
    assign b_mag = (is_signed && op_b[ex_pkg::xlen-1]) ? -op_b : op_b;
    assign last  = cnt == 7'(ex_pkg::xlen);

    // restoring step: shift in next dividend bit, try the subtract
    assign rem_sh = {hi, lo[ex_pkg::xlen-1]};
    assign diff   = rem_sh - {1'b0, b_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            md.done <= 1'b0;
        end else begin
            md.done <= 1'b0;
            if (md.start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy && last) begin
                busy    <= 1'b0;
                md.done <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md.start) begin
            f3_q  <= md.funct3;
            // x/0 keeps its sign out of it, quotient stays all ones
            neg_q <= is_signed && (op_a[ex_pkg::xlen-1] ^ op_b[ex_pkg::xlen-1]) && op_b != '0;
            hi    <= '0;
            lo    <= (md.funct3 == ex_pkg::f3_mul) ? op_b : a_mag;
            b_q   <= (md.funct3 == ex_pkg::f3_mul) ? op_a : b_mag;
        end else if (busy && !last) begin
            if (f3_q == ex_pkg::f3_mul) begin
                if (lo[0])
                    hi <= hi + b_q; // low 64 bits only
                b_q <= b_q << 1;
                lo  <= lo >> 1;
            end else if (!diff[ex_pkg::xlen]) begin // fits, keep the difference
                hi <= diff[ex_pkg::xlen-1:0];
                lo <= {lo[ex_pkg::xlen-2:0], 1'b1};
            end else begin
                hi <= rem_sh[ex_pkg::xlen-1:0];
                lo <= {lo[ex_pkg::xlen-2:0], 1'b0};
            end
        end else if (busy) begin
            // min / -1 falls out as the dividend, no special case
            md.result <= (f3_q == ex_pkg::f3_mul || f3_q == ex_pkg::f3_remu) ? hi :
                         neg_q ? -lo : lo;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (reset) md.start |-> !busy);

endmodule

// File: hdl/ex_stage.sv
module ex_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  logic [ex_pkg::xlen-1:0]      in_pc,
    input  logic [31:0]                  in_inst,
    input  logic [ex_pkg::xlen-1:0]      in_rs1_val,
    input  logic [ex_pkg::xlen-1:0]      in_rs2_val,
    input  logic                         branch_flush,
    input  logic                         mem_fwd_valid,
    input  logic [ex_pkg::reg_idx_w-1:0] mem_fwd_rd,
    input  logic [ex_pkg::xlen-1:0]      mem_fwd_data,
    input  logic                         wb_fwd_valid,
    input  logic [ex_pkg::reg_idx_w-1:0] wb_fwd_rd,
    input  logic [ex_pkg::xlen-1:0]      wb_fwd_data,
    input  logic                         out_ready,
    output logic                         in_ready,
    output logic                         out_valid,
    output logic [ex_pkg::xlen-1:0]      out_pc,
    output logic [ex_pkg::reg_idx_w-1:0] out_rd,
    output logic                         out_wen,
    output logic [ex_pkg::xlen-1:0]      out_result,
    output logic                         redirect,
    output logic [ex_pkg::xlen-1:0]      redirect_pc
);

    ex_pkg::inst_u           ex_inst;
    logic [ex_pkg::xlen-1:0] rs1_val;
    logic [ex_pkg::xlen-1:0] rs2_val;
    logic [ex_pkg::xlen-1:0] src1;    // after bypass
    logic [ex_pkg::xlen-1:0] src2;
    logic [1:0]              res_sel;
    logic                    is_jalr;
    logic                    is_branch_xfer;
    logic                    mispredict;

    muldiv_if md_bus ();

    ex_control ctrl_i (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
        .in_rs1_val(in_rs1_val), .in_rs2_val(in_rs2_val), .branch_flush(branch_flush),
        .out_ready(out_ready), .in_ready(in_ready), .out_valid(out_valid), .out_pc(out_pc),
        .out_wen(out_wen), .res_sel(res_sel), .is_jalr(is_jalr),
        .is_branch_xfer(is_branch_xfer), .ex_inst(ex_inst), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .md(md_bus.ctrl)
    );

    ex_forward fwd_i (
        .ex_inst(ex_inst), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .mem_fwd_valid(mem_fwd_valid), .mem_fwd_rd(mem_fwd_rd), .mem_fwd_data(mem_fwd_data),
        .wb_fwd_valid(wb_fwd_valid), .wb_fwd_rd(wb_fwd_rd), .wb_fwd_data(wb_fwd_data),
        .src1(src1), .src2(src2)
    );

    ex_alu alu_i (
        .ex_inst(ex_inst), .out_pc(out_pc), .src1(src1), .src2(src2), .res_sel(res_sel),
        .out_result(out_result), .md(md_bus.sink)
    );

    ex_branch br_i (
        .ex_inst(ex_inst), .out_pc(out_pc), .src1(src1), .src2(src2), .is_jalr(is_jalr),
        .mispredict(mispredict), .fix_pc(redirect_pc)
    );

    ex_muldiv md_i (
        .clk(clk), .reset(reset), .op_a(src1), .op_b(src2), .md(md_bus.unit)
    );

    assign out_rd   = ex_inst.r_view.rd;
    assign redirect = is_branch_xfer && mispredict; // only on the leaving cycle

endmodule

// File: testbench/ex_stage_tb.sv
module ex_stage_tb;

    localparam int n_insts = 400; // instructions offered to EX

    // what the model expects from one instruction
    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [63:0] result;
        logic        redirect;
        logic [63:0] fix_pc;
        logic        is_md; // variable latency
    } expect_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [63:0] in_pc;
    logic [31:0] in_inst;
    logic [63:0] in_rs1_val;
    logic [63:0] in_rs2_val;
    logic        branch_flush;
    logic        mem_fwd_valid;
    logic [4:0]  mem_fwd_rd;
    logic [63:0] mem_fwd_data;
    logic        wb_fwd_valid;
    logic [4:0]  wb_fwd_rd;
    logic [63:0] wb_fwd_data;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    logic [63:0] out_pc;
    logic [4:0]  out_rd;
    logic        out_wen;
    logic [63:0] out_result;
    logic        redirect;
    logic [63:0] redirect_pc;

    integer      seed = 47;
    int          errors = 0;
    int          checks = 0;
    int          accepted = 0;
    int          retired = 0;
    int          flushed = 0;
    logic        pending = 1'b0; // taken at the last edge, no model entry yet
    logic [31:0] pend_inst;
    logic [63:0] pend_pc;
    logic [63:0] pend_rs1;
    logic [63:0] pend_rs2;
    expect_t     exp_q[$];       // in-order model of the EX slot
    expect_t     head;

    ex_stage ex_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // longest divide plus drain and back-pressure stays well under 80 cycles each
    initial begin
        #(n_insts * 80 * 100);
        $display("watchdog: run did not finish within %0d cycles", n_insts * 80);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // operands biased toward the corner values
    function automatic logic [63:0] rand_val();
        case (rnd(8))
            0: return 64'd0;
            1: return '1;
            2: return 64'h8000_0000_0000_0000; // most negative
            3: return 64'(rnd(8));
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic logic [31:0] make_inst();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        int          kind;
        rs1  = 5'(rnd(8)); // small register range so bypass hits often
        rs2  = 5'(rnd(8));
        rd   = 5'(rnd(8));
        f3   = 3'(rnd(8));
        imm  = 12'(rnd(4096));
        kind = rnd(10);
        if (kind < 3) begin
            f7 = (f3 == ex_pkg::f3_add || f3 == ex_pkg::f3_srl) && rnd(2) == 1 ?
                 ex_pkg::f7_alt : ex_pkg::f7_base;
            return {f7, rs2, rs1, f3, rd, ex_pkg::op_reg};
        end else if (kind < 5) begin
            if (f3 == ex_pkg::f3_sll)
                imm[11:6] = 6'd0;
            else if (f3 == ex_pkg::f3_srl)
                imm[11:6] = rnd(2) == 1 ? 6'b010000 : 6'd0; // srai or srli
            return {imm, rs1, f3, rd, ex_pkg::op_imm};
        end else if (kind < 7) begin
            if (f3 == 3'b010 || f3 == 3'b011)
                f3 = ex_pkg::f3_beq; // no branch there
            return {imm[11:5], rs2, rs1, f3, imm[4:0], ex_pkg::op_branch};
        end else if (kind < 8) begin
            return {imm, rs1, 3'b000, rd, ex_pkg::op_jalr};
        end
        case (rnd(4))
            0: f3 = ex_pkg::f3_mul;
            1: f3 = ex_pkg::f3_div;
            2: f3 = ex_pkg::f3_divu;
            default: f3 = ex_pkg::f3_remu;
        endcase
        return {ex_pkg::f7_muldiv, rs2, rs1, f3, rd, ex_pkg::op_reg};
    endfunction

    // MEM first, then WB, x0 always reads its register value
    function automatic logic [63:0] fwd_model(input logic [4:0] rs, input logic [63:0] raw);
        if (rs != 5'd0 && mem_fwd_valid && mem_fwd_rd == rs)
            return mem_fwd_data;
        if (rs != 5'd0 && wb_fwd_valid && wb_fwd_rd == rs)
            return wb_fwd_data;
        return raw;
    endfunction

    function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $unsigned($signed(a) >>> b[5:0]);
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] muldiv_model(input logic [2:0] f3, input logic [63:0] a,
                                                 input logic [63:0] b);
        case (f3)
            3'b000: return a * b; // low half only
            3'b100: begin
                if (b == 64'd0)
                    return '1;
                if (a == 64'h8000_0000_0000_0000 && b == '1)
                    return a; // overflow gives the dividend back
                return $unsigned($signed(a) / $signed(b));
            end
            3'b101: return (b == 64'd0) ? '1 : a / b;
            default: return (b == 64'd0) ? a : a % b;
        endcase
    endfunction

    function automatic expect_t build_expect(input logic [31:0] inst, input logic [63:0] pc,
                                             input logic [63:0] raw1, input logic [63:0] raw2);
        expect_t     e;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] off_b;
        logic [2:0]  f3;
        logic        taken;
        a     = fwd_model(inst[19:15], raw1);
        b     = fwd_model(inst[24:20], raw2);
        f3    = inst[14:12];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        off_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        e     = '0;
        e.pc  = pc;
        e.rd  = inst[11:7];
        e.wen = inst[11:7] != 5'd0 && inst[6:0] != ex_pkg::op_branch;
        case (inst[6:0])
            ex_pkg::op_reg: begin
                e.is_md  = inst[31:25] == ex_pkg::f7_muldiv;
                e.result = e.is_md ? muldiv_model(f3, a, b) : alu_model(f3, inst[30], a, b);
            end
            ex_pkg::op_imm: e.result = alu_model(f3, inst[30] && f3 == 3'd5, a, imm_i);
            ex_pkg::op_branch: begin
                case (f3)
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    default: taken = a >= b;
                endcase
                e.redirect = taken != inst[31]; // backward offset was guessed taken
                e.fix_pc   = taken ? pc + off_b : pc + 64'd4;
            end
            default: begin // jalr
                e.result   = pc + 64'd4;
                e.redirect = 1'b1;
                e.fix_pc   = (a + imm_i) & ~64'd1;
            end
        endcase
        return e;
    endfunction

    initial begin
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_rs1_val    = '0;
        in_rs2_val    = '0;
        branch_flush  = 1'b0;
        mem_fwd_valid = 1'b0;
        mem_fwd_rd    = '0;
        mem_fwd_data  = '0;
        wb_fwd_valid  = 1'b0;
        wb_fwd_rd     = '0;
        wb_fwd_data   = '0;
        out_ready     = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check("reset out_valid", 64'd0, 64'(out_valid));
        check("reset redirect", 64'd0, 64'(redirect));
        check("reset in_ready", 64'd1, 64'(in_ready));

        while (accepted < n_insts || exp_q.size() != 0 || pending) begin
            @(negedge clk);
            if (pending) begin
                // new occupant gets its own bypass picture, held until it leaves
                mem_fwd_valid = rnd(2) == 1;
                mem_fwd_rd    = 5'(rnd(8));
                mem_fwd_data  = rand_val();
                wb_fwd_valid  = rnd(2) == 1;
                wb_fwd_rd     = 5'(rnd(8));
                wb_fwd_data   = rand_val();
                exp_q.push_back(build_expect(pend_inst, pend_pc, pend_rs1, pend_rs2));
                pending = 1'b0;
            end
            branch_flush = exp_q.size() != 0 && rnd(64) == 0;
            out_ready    = !branch_flush && rnd(4) != 0; // no output on a flush cycle
            in_valid     = accepted < n_insts && rnd(3) != 0;
            in_pc        = {32'd0, $random(seed)} & ~64'd3;
            in_inst      = make_inst();
            in_rs1_val   = rand_val();
            in_rs2_val   = rand_val();
            #1;
            if (exp_q.size() != 0)
                head = exp_q[0];
            if (out_valid && exp_q.size() == 0) begin
                errors++;
                $display("out_valid high with no instruction in EX at %0t", $time);
            end else if (out_valid) begin
                check("out_pc", head.pc, out_pc);
                check("out_rd", 64'(head.rd), 64'(out_rd));
                check("out_wen", 64'(head.wen), 64'(out_wen));
                check("out_result", head.result, out_result);
            end else if (exp_q.size() != 0 && !head.is_md) begin
                errors++;
                $display("ALU, branch or jalr in EX without out_valid at %0t", $time);
            end else if (exp_q.size() != 0 && in_ready) begin
                errors++;
                $display("input accepted while a multiply or divide runs at %0t", $time);
            end
            if (out_valid && out_ready && exp_q.size() != 0) begin
                check("redirect", 64'(head.redirect), 64'(redirect));
                if (head.redirect)
                    check("redirect_pc", head.fix_pc, redirect_pc);
                void'(exp_q.pop_front());
                retired++;
            end else begin
                check("redirect idle", 64'd0, 64'(redirect));
            end
            if (branch_flush) begin
                void'(exp_q.pop_front()); // gone, must never reach the output
                flushed++;
            end
            if (in_valid && in_ready) begin
                pending   = 1'b1;
                pend_inst = in_inst;
                pend_pc   = in_pc;
                pend_rs1  = in_rs1_val;
                pend_rs2  = in_rs2_val;
                accepted++;
            end
        end

        repeat (2) @(negedge clk);
        $display("errors %0d, checks %0d, retired %0d, flushed %0d", errors, checks, retired,
                 flushed);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# build the EX stage testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage.f \
    -o ex_stage_sim > build.log 2>&1 \
    && ./obj_dir/ex_stage_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: ex_stage.f
hdl/ex_pkg.sv
hdl/muldiv_if.sv
hdl/ex_control.sv
hdl/ex_forward.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_muldiv.sv
hdl/ex_stage.sv
testbench/ex_stage_tb.sv
